//--- bench/rvExecUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module rvExecUnitTb;

	localparam logic [31:0] ResetPc = 32'h0000_0000;
	localparam int MemWords = 256;
	localparam int NumRecords = 53;
	localparam int RecordWords = 8; // hex words per record line
	localparam int NumTests = 6;
	localparam int ResetCycles = 16;
	localparam int ClockPeriod = 10;
	localparam int TimeoutNs = (ResetCycles + NumRecords * 5) * ClockPeriod + 500;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [31:0] rdData;
		logic [3:0] test;
		logic [4:0] rd;
		logic rdWrite;
		logic illegal;
	} expected_s;

	logic clk = 1'b0;
	logic reset;
	logic instrValid;
	rvPkg::instrWord_u instr;
	logic retireValid;
	rvPkg::retire_s retire;

	logic [31:0] testWords [NumRecords * RecordWords];
	expected_s records [NumRecords];
	int testErrors [NumTests + 1];
	int checkIndex = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testsFailed = 0;
	logic [31:0] lastNextPc = ResetPc; // first retire must report ResetPc

	rvExecUnit #(
		.ResetPc(ResetPc),
		.MemWords(MemWords)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.retireValid(retireValid),
		.retire(retire)
	);

	always #(ClockPeriod / 2) clk = ~clk;

	function automatic string testName(input int t);
		case (t)
			1: return "reset and ordering";
			2: return "alu operations";
			3: return "loads and stores";
			4: return "control flow";
			5: return "upper immediates";
			default: return "illegal instructions";
		endcase
	endfunction

	task automatic compareField(input string name, input logic [31:0] expected,
		input logic [31:0] actual, input int test);
		checkCount++;
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s: expected %h, actual %h (record %0d)",
				name, expected, actual, checkIndex);
			errorCount++;
			testErrors[test]++;
		end
	endtask

	task automatic reportTest(input int t);
		if (testErrors[t] != 0)
			testsFailed++;
		$display("test %0d %s: %s, %0d errors", t, testName(t),
			(testErrors[t] == 0) ? "ok" : "errors found", testErrors[t]);
	endtask

	task automatic loadRecords();
		int base;
		$readmemh("bench/rvExecUnit_testdata.hex", testWords);
		for (int i = 0; i < NumRecords; i++)
		begin
			base = i * RecordWords;
			records[i].instr = testWords[base];
			records[i].pc = testWords[base + 1];
			records[i].nextPc = testWords[base + 2];
			records[i].rdData = testWords[base + 3];
			records[i].test = testWords[base + 4][3:0];
			records[i].rd = testWords[base + 5][4:0];
			records[i].rdWrite = testWords[base + 6][0];
			records[i].illegal = testWords[base + 7][0];
			assert (records[i].test != 4'd0)
			else
			begin
				$display("test data line %0d is missing or has no test number", i);
				errorCount++;
			end
		end
	endtask

	task automatic applyInput(input logic valid, input logic [31:0] word);
		instrValid = valid;
		instr = word;
		@(posedge clk);
		#1;
	endtask

	task automatic verifyRetire();
		expected_s rec;
		rec = records[checkIndex];
		compareField("retire.pc", rec.pc, retire.pc, int'(rec.test));
		compareField("retire.nextPc", rec.nextPc, retire.nextPc, int'(rec.test));
		compareField("retire.rdWrite", {31'd0, rec.rdWrite}, {31'd0, retire.rdWrite},
			int'(rec.test));
		compareField("retire.illegal", {31'd0, rec.illegal}, {31'd0, retire.illegal},
			int'(rec.test));
		if (rec.rdWrite)
		begin
			compareField("retire.rd", {27'd0, rec.rd}, {27'd0, retire.rd}, int'(rec.test));
			compareField("retire.rdData", rec.rdData, retire.rdData, int'(rec.test));
		end
		compareField("retire.pc after previous nextPc", lastNextPc, retire.pc, 1);
		lastNextPc = retire.nextPc;
		if (checkIndex == NumRecords - 1)
			reportTest(int'(rec.test));
		else if (records[checkIndex + 1].test != rec.test)
			reportTest(int'(rec.test)); // groups are contiguous in the file
		checkIndex++;
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (reset)
		begin
			assert (retireValid === 1'b0)
			else
			begin
				$display("retireValid was high during reset");
				errorCount++;
				testErrors[1]++;
			end
		end
		else if (retireValid === 1'b1)
		begin
			assert (checkIndex < NumRecords)
				verifyRetire();
			else
			begin
				$display("a retire arrived after the last expected record");
				errorCount++;
				testErrors[1]++;
			end
		end
	end

	initial
	begin
		int unsigned seedDiscard;
		int gap;
		seedDiscard = $urandom(32'heffded4f);
		reset = 1'b1;
		instrValid = 1'b1; // strobes held under reset must not retire
		instr = '0;
		for (int t = 0; t <= NumTests; t++)
			testErrors[t] = 0;
		loadRecords();
		repeat (ResetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
		instrValid = 1'b0;
		for (int i = 0; i < NumRecords; i++)
		begin
			gap = int'($urandom_range(3, 0)); // 0 gives back-to-back strobes
			repeat (gap) applyInput(1'b0, '0);
			applyInput(1'b1, records[i].instr);
		end
		applyInput(1'b0, '0);
		repeat (3) @(negedge clk); // room for a stray late retire
		compareField("retire count", NumRecords, checkIndex, 1);
		reportTest(1);
		$display("%0d tests, %0d passed, %0d failed; %0d checks, %0d errors",
			NumTests, NumTests - testsFailed, testsFailed, checkCount, errorCount);
		if (errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		#(TimeoutNs);
		$display("timeout: the run did not finish within %0d ns", TimeoutNs);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/rvExecUnit_testdata.hex
// columns: instr pc nextPc rdData test rd rdWrite illegal, all hex
// test 2 alu, 3 load and store, 4 control flow, 5 upper immediates, 6 illegal
00500093 00000000 00000004 00000005 2 01 1 0 // addi x1, x0, 5
FFD00113 00000004 00000008 FFFFFFFD 2 02 1 0 // addi x2, x0, -3
002081B3 00000008 0000000C 00000002 2 03 1 0 // add x3, x1, x2
40208233 0000000C 00000010 00000008 2 04 1 0 // sub x4, x1, x2
001092B3 00000010 00000014 000000A0 2 05 1 0 // sll x5, x1, x1
00112333 00000014 00000018 00000001 2 06 1 0 // slt x6, x2, x1
001133B3 00000018 0000001C 00000000 2 07 1 0 // sltu x7, x2, x1
0020C433 0000001C 00000020 FFFFFFF8 2 08 1 0 // xor x8, x1, x2
001154B3 00000020 00000024 07FFFFFF 2 09 1 0 // srl x9, x2, x1
40115533 00000024 00000028 FFFFFFFF 2 0A 1 0 // sra x10, x2, x1
0020E5B3 00000028 0000002C FFFFFFFD 2 0B 1 0 // or x11, x1, x2
0020F633 0000002C 00000030 00000005 2 0C 1 0 // and x12, x1, x2
00112693 00000030 00000034 00000001 2 0D 1 0 // slti x13, x2, 1
00113713 00000034 00000038 00000000 2 0E 1 0 // sltiu x14, x2, 1
FFF0C793 00000038 0000003C FFFFFFFA 2 0F 1 0 // xori x15, x1, -1
0700E813 0000003C 00000040 00000075 2 10 1 0 // ori x16, x1, 0x70
0F017893 00000040 00000044 000000F0 2 11 1 0 // andi x17, x2, 0xf0
01C09913 00000044 00000048 50000000 2 12 1 0 // slli x18, x1, 28
01C15993 00000048 0000004C 0000000F 2 13 1 0 // srli x19, x2, 28
40115A13 0000004C 00000050 FFFFFFFE 2 14 1 0 // srai x20, x2, 1
00708013 00000050 00000054 00000000 2 00 0 0 // addi x0, x1, 7
00100AB3 00000054 00000058 00000005 2 15 1 0 // add x21, x0, x1
04802023 00000058 0000005C 00000000 3 00 0 0 // sw x8, 0x40(x0)
041000A3 0000005C 00000060 00000000 3 00 0 0 // sb x1, 0x41(x0)
04201123 00000060 00000064 00000000 3 00 0 0 // sh x2, 0x42(x0)
04002B03 00000064 00000068 FFFD05F8 3 16 1 0 // lw x22, 0x40(x0)
04201B83 00000068 0000006C FFFFFFFD 3 17 1 0 // lh x23, 0x42(x0)
04205C03 0000006C 00000070 0000FFFD 3 18 1 0 // lhu x24, 0x42(x0)
04001C83 00000070 00000074 000005F8 3 19 1 0 // lh x25, 0x40(x0)
04000D03 00000074 00000078 FFFFFFF8 3 1A 1 0 // lb x26, 0x40(x0)
04004D83 00000078 0000007C 000000F8 3 1B 1 0 // lbu x27, 0x40(x0)
04100E03 0000007C 00000080 00000005 3 1C 1 0 // lb x28, 0x41(x0)
00C08463 00000080 00000088 00000000 4 00 0 0 // beq x1, x12, +8 taken
00C09463 00000088 0000008C 00000000 4 00 0 0 // bne x1, x12, +8 not taken
00114863 0000008C 0000009C 00000000 4 00 0 0 // blt x2, x1, +16 taken
00115863 0000009C 000000A0 00000000 4 00 0 0 // bge x2, x1, +16 not taken
00116863 000000A0 000000A4 00000000 4 00 0 0 // bltu x2, x1, +16 not taken
FE117EE3 000000A4 000000A0 00000000 4 00 0 0 // bgeu x2, x1, -4 taken
00208463 000000A0 000000A4 00000000 4 00 0 0 // beq x1, x2, +8 not taken
00209463 000000A4 000000AC 00000000 4 00 0 0 // bne x1, x2, +8 taken
0020C463 000000AC 000000B0 00000000 4 00 0 0 // blt x1, x2, +8 not taken
0020D463 000000B0 000000B8 00000000 4 00 0 0 // bge x1, x2, +8 taken
0020E463 000000B8 000000C0 00000000 4 00 0 0 // bltu x1, x2, +8 taken
0020F463 000000C0 000000C4 00000000 4 00 0 0 // bgeu x1, x2, +8 not taken
01000EEF 000000C4 000000D4 000000C8 4 1D 1 0 // jal x29, +16
0FCA8F67 000000D4 00000100 000000D8 4 1E 1 0 // jalr x30, 0xfc(x21), target 0x101
12345FB7 00000100 00000104 12345000 5 1F 1 0 // lui x31, 0x12345
80000197 00000104 00000108 80000104 5 03 1 0 // auipc x3, 0x80000
005000AB 00000108 0000010C 00000000 6 00 0 1 // custom opcode, rd x1
00003083 0000010C 00000110 00000000 6 00 0 1 // load with func3 3, rd x1
00C0A463 00000110 00000114 00000000 6 00 0 1 // branch with func3 2
00000073 00000114 00000118 00000000 6 00 0 1 // ecall
00008233 00000118 0000011C 00000005 6 04 1 0 // add x4, x1, x0 shows x1 kept

//--- run.sh
#!/usr/bin/env bash
# builds the rvExecUnit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module rvExecUnitTb \
	-f rvExecUnit.f \
	-o rvExecUnitSim
if [ $? -ne 0 ]; then
	echo "verilator build did not succeed"
	exit 1
fi

./obj_dir/rvExecUnitSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulator exited with status $simStatus"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" "$logFile"; then
	exit 0
fi
exit 1

//--- rvExecUnit.f
src/rvPkg.sv
src/instrDecode.sv
src/regFile.sv
src/alu.sv
src/dataMem.sv
src/pcUnit.sv
src/rvExecUnit.sv
bench/rvExecUnitTb.sv

//--- src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input rvPkg::aluOp_e op,
	input wire logic [31:0] a,
	input wire logic [31:0] b,
	output logic [31:0] result
);

	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = b[4:0];
	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	// compares land in bit 0, branch uses it as taken
	always_comb
	begin
		case (op)
			rvPkg::aluAdd: result = a + b;
			rvPkg::aluSub: result = a - b;
			rvPkg::aluSll: result = a << shamt;
			rvPkg::aluSlt: result = {31'd0, lessSigned};
			rvPkg::aluSltu: result = {31'd0, lessUnsigned};
			rvPkg::aluXor: result = a ^ b;
			rvPkg::aluSrl: result = a >> shamt;
			rvPkg::aluSra: result = $unsigned($signed(a) >>> shamt);
			rvPkg::aluOr: result = a | b;
			rvPkg::aluAnd: result = a & b;
			rvPkg::aluEqual: result = {31'd0, a == b};
			rvPkg::aluNotEqual: result = {31'd0, a != b};
			rvPkg::aluGreaterEqualSigned: result = {31'd0, ~lessSigned};
			rvPkg::aluGreaterEqualUnsigned: result = {31'd0, ~lessUnsigned};
			rvPkg::aluPassB: result = b;
			default: result = a + b;
		endcase
	end

endmodule

`default_nettype wire

//--- src/dataMem.sv
`timescale 1ns/100ps
`default_nettype none

module dataMem #(
	parameter int MemWords = 256
) (
	input wire logic clk,
	input wire logic [31:0] addr,
	input wire logic [31:0] writeData,
	input wire logic readEnable,
	input wire logic writeEnable,
	input rvPkg::memSize_e size,
	input wire logic isUnsigned,
	output logic [31:0] readData
);

	localparam int IndexBits = $clog2(MemWords);

	logic [31:0] mem [MemWords];
	logic [IndexBits-1:0] wordIndex;
	logic [31:0] laneData;
	logic [3:0] byteEnable;
	logic [31:0] wordRead;
	logic [31:0] shifted;

	assign wordIndex = addr[IndexBits+1:2]; // upper bits wrap

	// replicate store data onto every lane, enables pick the live ones
	always_comb
	begin
		case (size)
			rvPkg::memByte:
			begin
				laneData = {4{writeData[7:0]}};
				byteEnable = 4'b0001 << addr[1:0];
			end
			rvPkg::memHalf:
			begin
				laneData = {2{writeData[15:0]}};
				byteEnable = 4'b0011 << {addr[1], 1'b0};
			end
			default:
			begin
				laneData = writeData;
				byteEnable = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (writeEnable)
		begin
			for (int i = 0; i < 4; i++)
				if (byteEnable[i])
					mem[wordIndex][i*8 +: 8] <= laneData[i*8 +: 8];
		end
	end

	assign wordRead = mem[wordIndex];
	assign shifted = wordRead >> {addr[1:0], 3'b000}; // addressed lane to bit 0

	always_comb
	begin
		case (size)
			rvPkg::memByte: readData = {{24{~isUnsigned & shifted[7]}}, shifted[7:0]};
			rvPkg::memHalf: readData = {{16{~isUnsigned & shifted[15]}}, shifted[15:0]};
			default: readData = shifted;
		endcase
	end

	alignedAccess: assert property (@(posedge clk)
		(readEnable || writeEnable) |->
			(size == rvPkg::memByte) ||
			(size == rvPkg::memHalf && !addr[0]) ||
			(size == rvPkg::memWord && addr[1:0] == 2'b00))
		else $error("misaligned data access at %h", addr);

endmodule

`default_nettype wire

//--- src/instrDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecode (
	input rvPkg::instrWord_u instr,
	output rvPkg::decodeCtrl_s ctrl
);

	localparam logic [6:0] OpReg = 7'b0110011;
	localparam logic [6:0] OpImm = 7'b0010011;
	localparam logic [6:0] OpLoad = 7'b0000011;
	localparam logic [6:0] OpStore = 7'b0100011;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpJal = 7'b1101111;
	localparam logic [6:0] OpJalr = 7'b1100111;
	localparam logic [6:0] OpLui = 7'b0110111;
	localparam logic [6:0] OpAuipc = 7'b0010111;

	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immU;
	logic [31:0] immJ;
	rvPkg::aluOp_e arithOp;

	assign immI = {{20{instr.iType.imm11to0[11]}}, instr.iType.imm11to0};
	assign immS = {{20{instr.sType.imm11to5[6]}}, instr.sType.imm11to5, instr.sType.imm4to0};
	assign immB = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
		instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
	assign immU = {instr.uType.imm31to12, 12'h000};
	assign immJ = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
		instr.jType.imm11, instr.jType.imm10to1, 1'b0};

	// shared by reg-reg and reg-imm forms; bit 30 picks sub/sra
	always_comb
	begin
		case (instr.rType.func3)
			3'd0: arithOp = (instr.rType.opcode == OpReg && instr.rType.func7[5]) ?
				rvPkg::aluSub : rvPkg::aluAdd;
			3'd1: arithOp = rvPkg::aluSll;
			3'd2: arithOp = rvPkg::aluSlt;
			3'd3: arithOp = rvPkg::aluSltu;
			3'd4: arithOp = rvPkg::aluXor;
			3'd5: arithOp = instr.rType.func7[5] ? rvPkg::aluSra : rvPkg::aluSrl;
			3'd6: arithOp = rvPkg::aluOr;
			default: arithOp = rvPkg::aluAnd;
		endcase
	end

	always_comb
	begin
		ctrl = '0;
		ctrl.aluOp = rvPkg::aluAdd;
		ctrl.aSel = rvPkg::aRs1;
		ctrl.wbSel = rvPkg::wbAlu;
		ctrl.memSize = rvPkg::memWord;
		ctrl.rs1 = instr.rType.rs1; // same slots in every format
		ctrl.rs2 = instr.rType.rs2;
		ctrl.rd = instr.rType.rd;
		case (instr.rType.opcode)
			OpReg:
			begin
				ctrl.aluOp = arithOp;
				ctrl.regWrite = 1'b1;
			end
			OpImm:
			begin
				ctrl.aluOp = arithOp;
				ctrl.bImm = 1'b1;
				ctrl.imm = immI;
				ctrl.regWrite = 1'b1;
			end
			OpLoad:
			begin
				ctrl.bImm = 1'b1;
				ctrl.imm = immI;
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = rvPkg::wbLoad;
				ctrl.memUnsigned = instr.iType.func3[2];
				ctrl.memSize = rvPkg::memSize_e'(instr.iType.func3[1:0]);
				// lb lh lw lbu lhu only
				ctrl.illegal = (instr.iType.func3 == 3'd3) || (instr.iType.func3 > 3'd5);
			end
			OpStore:
			begin
				ctrl.bImm = 1'b1;
				ctrl.imm = immS;
				ctrl.memWrite = 1'b1;
				ctrl.memSize = rvPkg::memSize_e'(instr.sType.func3[1:0]);
				ctrl.illegal = instr.sType.func3 > 3'd2;
			end
			OpBranch:
			begin
				ctrl.imm = immB;
				ctrl.branch = 1'b1;
				case (instr.bType.func3)
					3'd0: ctrl.aluOp = rvPkg::aluEqual;
					3'd1: ctrl.aluOp = rvPkg::aluNotEqual;
					3'd4: ctrl.aluOp = rvPkg::aluSlt; // blt
					3'd5: ctrl.aluOp = rvPkg::aluGreaterEqualSigned;
					3'd6: ctrl.aluOp = rvPkg::aluSltu; // bltu
					3'd7: ctrl.aluOp = rvPkg::aluGreaterEqualUnsigned;
					default: ctrl.illegal = 1'b1;
				endcase
			end
			OpJal:
			begin
				ctrl.aSel = rvPkg::aPc;
				ctrl.bImm = 1'b1;
				ctrl.imm = immJ;
				ctrl.jump = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = rvPkg::wbPc4;
			end
			OpJalr:
			begin
				ctrl.bImm = 1'b1; // alu forms rs1 + imm target
				ctrl.imm = immI;
				ctrl.jalr = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = rvPkg::wbPc4;
				ctrl.illegal = instr.iType.func3 != 3'd0;
			end
			OpLui:
			begin
				ctrl.aluOp = rvPkg::aluPassB;
				ctrl.aSel = rvPkg::aZero;
				ctrl.bImm = 1'b1;
				ctrl.imm = immU;
				ctrl.regWrite = 1'b1;
			end
			OpAuipc:
			begin
				ctrl.aSel = rvPkg::aPc;
				ctrl.bImm = 1'b1;
				ctrl.imm = immU;
				ctrl.regWrite = 1'b1;
			end
			default: ctrl.illegal = 1'b1; // fence, system and unknown
		endcase
		if (ctrl.illegal)
		begin
			ctrl.regWrite = 1'b0;
			ctrl.memRead = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.branch = 1'b0;
			ctrl.jump = 1'b0;
			ctrl.jalr = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- src/pcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module pcUnit #(
	parameter logic [31:0] ResetPc = 32'h0000_0000
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic advance,
	input rvPkg::decodeCtrl_s ctrl,
	input wire logic [31:0] aluResult,
	output logic [31:0] pc,
	output logic [31:0] nextPc
);

	logic [31:0] pcPlus4;
	logic [31:0] pcTarget;
	logic taken;

	assign pcPlus4 = pc + 32'd4;
	assign pcTarget = pc + ctrl.imm; // branch and jal
	assign taken = ctrl.branch & aluResult[0];

	always_comb
	begin
		if (ctrl.jalr)
			nextPc = {aluResult[31:1], 1'b0}; // rs1 + imm, bit 0 dropped
		else if (ctrl.jump || taken)
			nextPc = pcTarget;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= ResetPc;
		else if (advance)
			pc <= nextPc;
	end

	pcAligned: assert property (@(posedge clk) disable iff (reset)
		advance |=> pc[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic reset,
	input wire logic [4:0] rs1,
	input wire logic [4:0] rs2,
	input wire logic [4:0] rd,
	input wire logic writeEnable,
	input wire logic [31:0] writeData,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data
);

	logic [31:0] regs [32];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && rd != 5'd0) // x0 stays zero
		begin
			regs[rd] <= writeData;
		end
	end

	// same-cycle read sees the old value
	assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- src/rvExecUnit.sv
`timescale 1ns/100ps
`default_nettype none

module rvExecUnit #(
	parameter logic [31:0] ResetPc = 32'h0000_0000,
	parameter int MemWords = 256
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic instrValid,
	input rvPkg::instrWord_u instr,
	output logic retireValid,
	output rvPkg::retire_s retire
);

	rvPkg::decodeCtrl_s ctrl;
	logic [31:0] rs1Data;
	logic [31:0] rs2Data;
	logic [31:0] aluA;
	logic [31:0] aluB;
	logic [31:0] aluResult;
	logic [31:0] loadData;
	logic [31:0] pc;
	logic [31:0] nextPc;
	logic [31:0] wbData;
	logic rdWrite;

	instrDecode decode0 (
		.instr(instr),
		.ctrl(ctrl)
	);

	regFile regs0 (
		.clk(clk),
		.reset(reset),
		.rs1(ctrl.rs1),
		.rs2(ctrl.rs2),
		.rd(ctrl.rd),
		.writeEnable(instrValid & ctrl.regWrite),
		.writeData(wbData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	always_comb
	begin
		case (ctrl.aSel)
			rvPkg::aPc: aluA = pc;
			rvPkg::aZero: aluA = '0;
			default: aluA = rs1Data;
		endcase
	end

	assign aluB = ctrl.bImm ? ctrl.imm : rs2Data;

	alu alu0 (
		.op(ctrl.aluOp),
		.a(aluA),
		.b(aluB),
		.result(aluResult)
	);

	dataMem #(
		.MemWords(MemWords)
	) mem0 (
		.clk(clk),
		.addr(aluResult),
		.writeData(rs2Data),
		.readEnable(instrValid & ctrl.memRead),
		.writeEnable(instrValid & ctrl.memWrite),
		.size(ctrl.memSize),
		.isUnsigned(ctrl.memUnsigned),
		.readData(loadData)
	);

	pcUnit #(
		.ResetPc(ResetPc)
	) pc0 (
		.clk(clk),
		.reset(reset),
		.advance(instrValid),
		.ctrl(ctrl),
		.aluResult(aluResult),
		.pc(pc),
		.nextPc(nextPc)
	);

	always_comb
	begin
		case (ctrl.wbSel)
			rvPkg::wbLoad: wbData = loadData;
			rvPkg::wbPc4: wbData = pc + 32'd4; // link address
			default: wbData = aluResult;
		endcase
	end

	assign rdWrite = ctrl.regWrite && ctrl.rd != 5'd0;

	always_ff @(posedge clk)
	begin
		if (reset)
			retireValid <= 1'b0;
		else
			retireValid <= instrValid;
	end

	// record captured at the strobe edge, shown one cycle later
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			retire.pc <= pc;
			retire.nextPc <= nextPc;
			retire.rd <= ctrl.rd;
			retire.rdWrite <= rdWrite;
			retire.rdData <= rdWrite ? wbData : '0;
			retire.illegal <= ctrl.illegal;
		end
	end

	retireFollowsStrobe: assert property (@(posedge clk) disable iff (reset)
		retireValid |-> $past(instrValid))
		else $error("retire without a strobe in the previous cycle");

endmodule

`default_nettype wire

//--- src/rvPkg.sv
`default_nettype none

package rvPkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluEqual,
		aluNotEqual,
		aluGreaterEqualSigned,
		aluGreaterEqualUnsigned,
		aluPassB // lui
	} aluOp_e;

	// RV32I base formats, msb first
	typedef struct packed {
		logic [6:0] func7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rType_s;

	typedef struct packed {
		logic [11:0] imm11to0;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iType_s;

	typedef struct packed {
		logic [6:0] imm11to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [4:0] imm4to0;
		logic [6:0] opcode;
	} sType_s;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [3:0] imm4to1;
		logic imm11;
		logic [6:0] opcode;
	} bType_s;

	typedef struct packed {
		logic [19:0] imm31to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} uType_s;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jType_s;

	// one word, six ways to read it
	typedef union packed {
		rType_s rType;
		iType_s iType;
		sType_s sType;
		bType_s bType;
		uType_s uType;
		jType_s jType;
	} instrWord_u;

	typedef enum logic [1:0] {
		memByte,
		memHalf,
		memWord
	} memSize_e;

	typedef enum logic [1:0] {
		aRs1,
		aPc,
		aZero
	} aSel_e;

	typedef enum logic [1:0] {
		wbAlu,
		wbLoad,
		wbPc4
	} wbSel_e;

	typedef struct packed {
		aluOp_e aluOp;
		aSel_e aSel;
		logic bImm; // operand b from imm, not rs2
		logic [31:0] imm;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic regWrite;
		logic memRead;
		logic memWrite;
		memSize_e memSize;
		logic memUnsigned;
		logic branch;
		logic jump;
		logic jalr;
		wbSel_e wbSel;
		logic illegal;
	} decodeCtrl_s;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [4:0] rd;
		logic rdWrite; // real write, rd not x0
		logic [31:0] rdData;
		logic illegal;
	} retire_s;

endpackage

`default_nettype wire
